//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := uart_tb
FILELIST  := uart_loop.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/uart_checker.sv
module uart_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic tx_busy_i,       // tx_busy_o of the top
    input logic uart_tx_i,       // serial line out
    input logic rx_valid_i,
    input logic rx_frame_err_i
);

    ////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////

    // idle transmitter must hold the mark level
    a_idle_line: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !tx_busy_i |-> uart_tx_i)
        else $error("serial line low while transmitter is idle");

    ////////////////////////////////////////
    // receive side
    ////////////////////////////////////////

    a_rx_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rx_valid_i && rx_frame_err_i))
        else $error("valid and frame error high in the same cycle");

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_valid_i |=> !rx_valid_i)
        else $error("rx valid held for more than one cycle");

    a_err_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_frame_err_i |=> !rx_frame_err_i)
        else $error("frame error held for more than one cycle");

endmodule

bind uart_top uart_checker u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .tx_busy_i      (tx_busy_o),
    .uart_tx_i      (uart_tx_o),
    .rx_valid_i     (rx_valid_o),
    .rx_frame_err_i (rx_frame_err_o)
);

//--- sim/uart_tb.sv
module uart_tb
    import uart_pkg::*;
();

    localparam int BAUD = 16;      // short bit period for sim
    localparam int N_LOOP = 40;

    logic                 clk_i;
    logic                 rst_n_i;
    logic [DATA_BITS-1:0] tx_data_i;
    logic                 tx_en_i;
    logic                 tx_busy_o;
    logic                 uart_tx_o;
    logic                 uart_rx_i;
    logic [DATA_BITS-1:0] rx_data_o;
    logic                 rx_valid_o;
    logic                 rx_frame_err_o;

    logic                 loop_sel;    // 1 loopback, 0 injected line
    logic                 inj_line;
    logic [DATA_BITS-1:0] exp_q[$];    // bytes accepted by the transmitter
    logic [DATA_BITS-1:0] head_byte;
    logic [DATA_BITS-1:0] byte_a;
    logic [DATA_BITS-1:0] byte_b;
    logic [DATA_BITS-1:0] held_data;
    int                   valid_cnt;
    int                   err_cnt;
    int                   v0;
    int                   e0;

    assign uart_rx_i = loop_sel ? uart_tx_o : inj_line;

    uart_top #(
        .BAUD_DIV (DIV_W'(BAUD))
    ) DUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .tx_data_i      (tx_data_i),
        .tx_en_i        (tx_en_i),
        .tx_busy_o      (tx_busy_o),
        .uart_tx_o      (uart_tx_o),
        .uart_rx_i      (uart_rx_i),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_eq(input logic [31:0] exp, input logic [31:0] act, input string name);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at t=%0t while waiting for %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    // drive one enable; the model takes the byte only if the tx is free
    task automatic pulse_en(input logic [DATA_BITS-1:0] data);
        tx_data_i = data;
        tx_en_i   = 1'b1;
        if (!tx_busy_o) exp_q.push_back(data);
        @(posedge clk_i);
        #1;
        tx_en_i = 1'b0;
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_busy_o) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > 12 * BAUD) fail_timeout("tx_busy_o to fall");
        end
    endtask

    task automatic wait_rx_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > 24 * BAUD) fail_timeout("expected bytes to be received");
        end
    endtask

    task automatic wait_err_pulse(input int base);
        int n;
        n = 0;
        while (err_cnt == base) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n > 12 * BAUD) fail_timeout("rx_frame_err_o pulse");
        end
    endtask

    // bit-bang a frame on the injected line, stop level chosen by caller
    task automatic inject_frame(input logic [DATA_BITS-1:0] data, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int k = 0; k < 10; k++) begin
            inj_line = frame[k];
            repeat (BAUD) @(posedge clk_i);
            #1;
        end
        inj_line = 1'b1;
        repeat (2 * BAUD) @(posedge clk_i);
        #1;
    endtask

    // sample each bit centre from the accepting edge, then time the busy fall
    task automatic check_tx_waveform(input logic [DATA_BITS-1:0] data);
        logic [9:0] frame;
        int         n;
        int         k;
        frame = {1'b1, data, 1'b0};
        n     = 0;
        k     = 0;
        wait_tx_idle();
        pulse_en(data);                             // now just after edge E
        check_eq(32'(1'b1), 32'(tx_busy_o), "tx_busy_o");
        while (tx_busy_o) begin
            @(posedge clk_i);
            #1;
            n++;
            // value seen here is the one sampled at edge E+n+1
            if (k < 10 && n == k * BAUD + BAUD / 2) begin
                check_eq(32'(frame[k]), 32'(uart_tx_o), "uart_tx_o");
                k++;
            end
            if (n > 12 * BAUD) fail_timeout("end of transmit frame");
        end
        check_eq(32'(10), 32'(k), "uart_tx_o bit samples");
        // busy first sampled low at edge E+n+1
        check_eq(32'(10 * BAUD + 1), 32'(n + 1), "tx_busy_o fall edge");
    endtask

    ////////////////////////////////////////
    // receive monitor, mid-cycle sampling
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (rx_frame_err_o) err_cnt++;
            if (rx_valid_o) begin
                valid_cnt++;
                if (exp_q.size() == 0) begin
                    $display("rx_valid_o pulsed at t=%0t with no byte outstanding", $time);
                    $display("Simulation FAILED");
                    $fatal(1, "unexpected byte");
                end else begin
                    head_byte = exp_q.pop_front();
                    check_eq(32'(head_byte), 32'(rx_data_o), "rx_data_o");
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_n_i   = 1'b0;
        tx_data_i = '0;
        tx_en_i   = 1'b0;
        loop_sel  = 1'b1;
        inj_line  = 1'b1;
        valid_cnt = 0;
        err_cnt   = 0;
        void'($urandom(64));

        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // quiet outputs after reset
        for (int i = 0; i < 8; i++) begin
            check_eq(32'(1'b1), 32'(uart_tx_o), "uart_tx_o");
            check_eq(32'(1'b0), 32'(tx_busy_o), "tx_busy_o");
            check_eq(32'(1'b0), 32'(rx_valid_o), "rx_valid_o");
            check_eq(32'(1'b0), 32'(rx_frame_err_o), "rx_frame_err_o");
            @(posedge clk_i);
            #1;
        end

        check_tx_waveform(DATA_BITS'($urandom));
        wait_rx_drain();

        // back to back loopback
        for (int i = 0; i < N_LOOP; i++) begin
            wait_tx_idle();
            pulse_en(DATA_BITS'($urandom));
        end
        wait_tx_idle();
        wait_rx_drain();
        check_eq(32'(0), 32'(err_cnt), "rx_frame_err_o count");

        // second enable mid-frame must be dropped
        v0     = valid_cnt;
        byte_a = DATA_BITS'($urandom);
        byte_b = byte_a ^ DATA_BITS'(1 + $urandom % 255);  // never equal to byte_a
        pulse_en(byte_a);
        repeat (3 * BAUD) @(posedge clk_i);
        #1;
        check_eq(32'(1'b1), 32'(tx_busy_o), "tx_busy_o");
        pulse_en(byte_b);
        wait_tx_idle();
        wait_rx_drain();
        repeat (12 * BAUD) @(posedge clk_i);  // room for a stray second frame
        #1;
        check_eq(32'(v0 + 1), 32'(valid_cnt), "rx_valid_o count");

        // bad stop bit on the injected line, then a good frame
        loop_sel  = 1'b0;
        v0        = valid_cnt;
        e0        = err_cnt;
        held_data = rx_data_o;
        byte_b    = held_data ^ DATA_BITS'(1 + $urandom % 255);  // differs from held byte
        inject_frame(byte_b, 1'b0);
        wait_err_pulse(e0);
        check_eq(32'(e0 + 1), 32'(err_cnt), "rx_frame_err_o count");
        check_eq(32'(v0), 32'(valid_cnt), "rx_valid_o count");
        check_eq(32'(held_data), 32'(rx_data_o), "rx_data_o");

        byte_a = DATA_BITS'($urandom);
        exp_q.push_back(byte_a);
        inject_frame(byte_a, 1'b1);
        wait_rx_drain();
        check_eq(32'(v0 + 1), 32'(valid_cnt), "rx_valid_o count");
        check_eq(32'(e0 + 1), 32'(err_cnt), "rx_frame_err_o count");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////
    // frame format
    ////////////////////////////////////////

    // payload bits per frame, sent lsb first
    localparam int DATA_BITS = 8;

    localparam int FRAME_BITS = DATA_BITS + 2;  // start + data + stop

    localparam logic LINE_IDLE = 1'b1;  // mark level, also the stop bit

    ////////////////////////////////////////
    // baud generation
    ////////////////////////////////////////

    // counter width, wide enough for 50 MHz at 9600 baud
    localparam int DIV_W = 13;

    // clocks per bit, 50 MHz / 9600
    localparam int DEFAULT_BAUD_DIV = 5208;

endpackage

//--- source/uart_rx_path.sv
module uart_rx_path
    import uart_pkg::*;
#(
    parameter logic [DIV_W-1:0] BAUD_DIV = DIV_W'(DEFAULT_BAUD_DIV)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 uart_rx_i,       // async serial line
    output logic [DATA_BITS-1:0] rx_data_o,       // last good byte
    output logic                 rx_valid_o,      // one-cycle pulse
    output logic                 rx_frame_err_o   // one-cycle pulse, stop bit low
);

    localparam logic [DIV_W-1:0] LAST_CNT = BAUD_DIV - 1'b1;
    localparam logic [DIV_W-1:0] HALF_CNT = (BAUD_DIV >> 1) - 1'b1;  // edge to start centre
    localparam int               BIT_W    = $clog2(FRAME_BITS);
    localparam logic [BIT_W-1:0] STOP_IDX = BIT_W'(FRAME_BITS - 1);

    logic                 rx_meta;     // first sync stage
    logic                 rx_sync;     // safe to use
    logic                 rx_prev;     // for edge detect
    logic                 busy;        // frame in progress
    logic [DIV_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]     bit_idx;     // 0 start, 1..8 data, 9 stop
    logic [DATA_BITS-1:0] data_sr;
    logic                 fall;
    logic                 sample;
    logic                 stop_smp;
    logic                 data_smp;

    ////////////////////////////////////////
    // synchroniser and edge detect
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_meta <= LINE_IDLE;
            rx_sync <= LINE_IDLE;
            rx_prev <= LINE_IDLE;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = (rx_prev == LINE_IDLE) && (rx_sync != LINE_IDLE);

    // half period for the start bit, full periods after that
    assign sample   = busy && (baud_cnt == ((bit_idx == '0) ? HALF_CNT : LAST_CNT));
    assign stop_smp = sample && (bit_idx == STOP_IDX);
    assign data_smp = sample && (bit_idx != '0) && !stop_smp;

    ////////////////////////////////////////
    // bit timing and status pulses
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy           <= 1'b0;
            baud_cnt       <= '0;
            bit_idx        <= '0;
            rx_valid_o     <= 1'b0;
            rx_frame_err_o <= 1'b0;
        end else begin
            rx_valid_o     <= 1'b0;     // pulses by default
            rx_frame_err_o <= 1'b0;
            if (!busy) begin
                baud_cnt <= '0;
                bit_idx  <= '0;
                busy     <= fall;       // edge only counts while idle
            end else if (!sample) begin
                baud_cnt <= baud_cnt + 1'b1;
            end else begin
                baud_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == '0) begin
                    // start bit gone high at its centre, treat as noise
                    if (rx_sync == LINE_IDLE) begin
                        busy <= 1'b0;
                    end
                end else if (stop_smp) begin
                    busy           <= 1'b0;
                    rx_valid_o     <= (rx_sync == LINE_IDLE);
                    rx_frame_err_o <= (rx_sync != LINE_IDLE);
                end
            end
        end
    end

    ////////////////////////////////////////
    // data capture
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (data_smp) begin
            data_sr <= {rx_sync, data_sr[DATA_BITS-1:1]};  // lsb arrives first
        end
    end

    // byte held until the next good frame, bad frames leave it alone
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_data_o <= '0;
        end else if (stop_smp && (rx_sync == LINE_IDLE)) begin
            rx_data_o <= data_sr;
        end
    end

endmodule

//--- source/uart_top.sv
module uart_top
    import uart_pkg::*;
#(
    parameter logic [DIV_W-1:0] BAUD_DIV = DIV_W'(DEFAULT_BAUD_DIV)  // clocks per bit
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // transmit side
    input  logic [DATA_BITS-1:0] tx_data_i,
    input  logic                 tx_en_i,         // ignored while busy
    output logic                 tx_busy_o,
    output logic                 uart_tx_o,

    // receive side
    input  logic                 uart_rx_i,
    output logic [DATA_BITS-1:0] rx_data_o,
    output logic                 rx_valid_o,
    output logic                 rx_frame_err_o
);

    ////////////////////////////////////////
    // paths are independent, loopback is external
    ////////////////////////////////////////

    uart_tx_path #(
        .BAUD_DIV (BAUD_DIV)
    ) u_tx_path (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .tx_data_i (tx_data_i),
        .tx_en_i   (tx_en_i),
        .tx_busy_o (tx_busy_o),
        .uart_tx_o (uart_tx_o)
    );

    uart_rx_path #(
        .BAUD_DIV (BAUD_DIV)
    ) u_rx_path (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .uart_rx_i      (uart_rx_i),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

endmodule

//--- source/uart_tx_path.sv
module uart_tx_path
    import uart_pkg::*;
#(
    parameter logic [DIV_W-1:0] BAUD_DIV = DIV_W'(DEFAULT_BAUD_DIV)
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [DATA_BITS-1:0] tx_data_i,  // byte to send
    input  logic                 tx_en_i,    // one-cycle start strobe
    output logic                 tx_busy_o,  // high for the whole frame
    output logic                 uart_tx_o   // serial line
);

    localparam logic [DIV_W-1:0] LAST_CNT = BAUD_DIV - 1'b1;  // last count of a bit period
    localparam int               BIT_W    = $clog2(FRAME_BITS);

    logic [DIV_W-1:0]      baud_cnt;   // position inside the current bit
    logic                  bit_tick;   // last cycle of a bit period
    logic [BIT_W-1:0]      bit_cnt;    // index of the bit now on the line
    logic [FRAME_BITS-1:0] frame_sr;   // bit 0 drives the line
    logic                  start;
    logic                  last_bit;

    // enables while busy are dropped here
    assign start    = tx_en_i & ~tx_busy_o;
    assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

    // line comes straight from the frame register
    assign uart_tx_o = frame_sr[0];

    ////////////////////////////////////////
    // baud counter
    ////////////////////////////////////////

    // line moves on the edge right after the last count
    assign bit_tick = tx_busy_o && (baud_cnt == LAST_CNT);

    // counter is parked at zero between frames, so the first
    // period starts together with the load
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            baud_cnt <= '0;
        end else if (!tx_busy_o || bit_tick) begin
            baud_cnt <= '0;         // idle or wrap at end of a bit
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // frame shifter and busy flag
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tx_busy_o <= 1'b0;
            bit_cnt   <= '0;
            frame_sr  <= {FRAME_BITS{LINE_IDLE}};   // line high out of reset
        end else if (start) begin
            tx_busy_o <= 1'b1;
            bit_cnt   <= '0;
            // stop, data, start; start bit hits the line right away
            frame_sr  <= {LINE_IDLE, tx_data_i, ~LINE_IDLE};
        end else if (bit_tick) begin
            // idle level fills in from the top
            frame_sr <= {LINE_IDLE, frame_sr[FRAME_BITS-1:1]};
            if (last_bit) begin
                tx_busy_o <= 1'b0;  // stop bit done
                bit_cnt   <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- uart_loop.f
source/uart_pkg.sv
source/uart_tx_path.sv
source/uart_rx_path.sv
source/uart_top.sv
sim/uart_checker.sv
sim/uart_tb.sv
